/* hdl/decoder_pkg.sv */
// decode stage types for the RV32 decoder
// opcodes, ALU and mux select encodings, packed control result
package decoder_pkg;

  //////////////////////////////
  // encodings
  //////////////////////////////

  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OPIMM  = 7'h13,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JALR   = 7'h67,
    OPCODE_JAL    = 7'h6f,
    OPCODE_SYSTEM = 7'h73
  } opcode_e;

  typedef enum logic [5:0] {
    ALU_ADD  = 6'b011000,
    ALU_SUB  = 6'b011001,
    ALU_XOR  = 6'b101111,
    ALU_OR   = 6'b101110,
    ALU_AND  = 6'b010101,
    ALU_SRA  = 6'b100100,
    ALU_SRL  = 6'b100101,
    ALU_SLL  = 6'b100111,
    ALU_LTS  = 6'b000000, // compares, used by branches
    ALU_LTU  = 6'b000001,
    ALU_SLTS = 6'b000010, // set-less-than, writes rd
    ALU_SLTU = 6'b000011,
    ALU_GES  = 6'b001010,
    ALU_GEU  = 6'b001011,
    ALU_EQ   = 6'b001100,
    ALU_NE   = 6'b001101
  } alu_op_e;

  typedef enum logic [2:0] {
    OP_A_REGA   = 3'b000, // rs1
    OP_A_CURRPC = 3'b001,
    OP_A_IMM    = 3'b010
  } op_a_sel_e;

  typedef enum logic [2:0] {
    OP_B_REGB = 3'b000, // rs2
    OP_B_IMM  = 3'b010
  } op_b_sel_e;

  typedef enum logic [0:0] {
    IMMA_Z    = 1'b0, // zero-extended rs1 field
    IMMA_ZERO = 1'b1
  } imm_a_sel_e;

  typedef enum logic [3:0] {
    IMMB_I      = 4'b0000,
    IMMB_S      = 4'b0001,
    IMMB_U      = 4'b0010,
    IMMB_PCINCR = 4'b0011, // constant 4 for link address
    IMMB_UJ     = 4'b1100,
    IMMB_SB     = 4'b1101
  } imm_b_sel_e;

  typedef enum logic [1:0] {MD_OP_MULL, MD_OP_MULH, MD_OP_DIV, MD_OP_REM} md_op_e;

  typedef enum logic [1:0] {CSR_OP_NONE, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR} csr_op_e;

  typedef enum logic [1:0] {
    DATA_WORD = 2'b00,
    DATA_HALF = 2'b01,
    DATA_BYTE = 2'b10
  } data_type_e;

  //////////////////////////////
  // request and result
  //////////////////////////////

  typedef struct packed {
    logic [31:0] instr;
    logic        target_phase; // set: jump/branch target phase
  } instr_req_t;

  typedef struct packed {
    alu_op_e    alu_operator;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_a_sel_e imm_a_sel;
    imm_b_sel_e imm_b_sel;
    logic       mult_en;
    logic       div_en;
    md_op_e     md_operator;
    logic [1:0] md_signed_mode; // {op_b signed, op_a signed}
    logic       regfile_we;
    logic       csr_access;
    csr_op_e    csr_op;
    logic       csr_status;     // mstatus touched
    logic       data_req;
    logic       data_we;
    data_type_e data_type;
    logic       data_sign_ext;
    logic       jump;
    logic       branch;
    logic       illegal;
    logic       ecall;
    logic       ebreak;
    logic       mret;
    logic       wfi_flush;
  } dec_ctrl_t;

  // result before any group claims the instruction
  localparam dec_ctrl_t dec_ctrl_default = '{
    alu_operator:   ALU_SLTU,
    op_a_sel:       OP_A_REGA,
    op_b_sel:       OP_B_REGB,
    imm_a_sel:      IMMA_ZERO,
    imm_b_sel:      IMMB_I,
    mult_en:        1'b0,
    div_en:         1'b0,
    md_operator:    MD_OP_MULL,
    md_signed_mode: 2'b00,
    regfile_we:     1'b0,
    csr_access:     1'b0,
    csr_op:         CSR_OP_NONE,
    csr_status:     1'b0,
    data_req:       1'b0,
    data_we:        1'b0,
    data_type:      DATA_WORD,
    data_sign_ext:  1'b0,
    jump:           1'b0,
    branch:         1'b0,
    illegal:        1'b0,
    ecall:          1'b0,
    ebreak:         1'b0,
    mret:           1'b0,
    wfi_flush:      1'b0
  };

endpackage

/* hdl/ctrl_flow_decoder.sv */
// control flow decoder for JAL, JALR and BRANCH
// target phase computes the target or compares, the other phase links or adds
module ctrl_flow_decoder (
  input  decoder_pkg::instr_req_t instr_i,
  output logic                    hit_o,
  output decoder_pkg::dec_ctrl_t  ctrl_o
);
  import decoder_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       is_jump;

  assign opcode  = opcode_e'(instr_i.instr[6:0]);
  assign funct3  = instr_i.instr[14:12];
  assign is_jump = (opcode == OPCODE_JAL) || (opcode == OPCODE_JALR);
  assign hit_o   = is_jump || (opcode == OPCODE_BRANCH);

  always_comb begin
    ctrl_o = dec_ctrl_default;
    if (is_jump) begin
      ctrl_o.jump         = 1'b1;
      ctrl_o.alu_operator = ALU_ADD;
      ctrl_o.op_b_sel     = OP_B_IMM;
      if (instr_i.target_phase) begin
        if (opcode == OPCODE_JAL) begin
          ctrl_o.op_a_sel  = OP_A_CURRPC; // pc + uj imm
          ctrl_o.imm_b_sel = IMMB_UJ;
        end else begin
          ctrl_o.op_a_sel  = OP_A_REGA;   // rs1 + i imm
          ctrl_o.imm_b_sel = IMMB_I;
        end
      end else begin
        // link value pc + 4 into rd
        ctrl_o.op_a_sel   = OP_A_CURRPC;
        ctrl_o.imm_b_sel  = IMMB_PCINCR;
        ctrl_o.regfile_we = 1'b1;
      end
      if ((opcode == OPCODE_JALR) && (funct3 != 3'b000)) begin
        ctrl_o.jump       = 1'b0;
        ctrl_o.regfile_we = 1'b0;
        ctrl_o.illegal    = 1'b1;
      end
    end else if (opcode == OPCODE_BRANCH) begin
      ctrl_o.branch = 1'b1;
      if (instr_i.target_phase) begin
        unique case (funct3) // rs1 vs rs2 compare
          3'b000:  ctrl_o.alu_operator = ALU_EQ;
          3'b001:  ctrl_o.alu_operator = ALU_NE;
          3'b100:  ctrl_o.alu_operator = ALU_LTS;
          3'b101:  ctrl_o.alu_operator = ALU_GES;
          3'b110:  ctrl_o.alu_operator = ALU_LTU;
          3'b111:  ctrl_o.alu_operator = ALU_GEU;
          default: ctrl_o.illegal      = 1'b1; // 010, 011
        endcase
      end else begin
        ctrl_o.op_a_sel     = OP_A_CURRPC; // pc + sb imm
        ctrl_o.op_b_sel     = OP_B_IMM;
        ctrl_o.imm_b_sel    = IMMB_SB;
        ctrl_o.alu_operator = ALU_ADD;
      end
    end
  end

endmodule

/* hdl/mem_access_decoder.sv */
// load/store decoder
// address add, access size, sign extension and store legality
module mem_access_decoder (
  input  decoder_pkg::instr_req_t instr_i,
  output logic                    hit_o,
  output decoder_pkg::dec_ctrl_t  ctrl_o
);
  import decoder_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;

  assign opcode = opcode_e'(instr_i.instr[6:0]);
  assign funct3 = instr_i.instr[14:12];
  assign hit_o  = (opcode == OPCODE_LOAD) || (opcode == OPCODE_STORE);

  always_comb begin
    ctrl_o = dec_ctrl_default;
    if (hit_o) begin
      ctrl_o.data_req     = 1'b1;
      ctrl_o.alu_operator = ALU_ADD; // rs1 + offset
      ctrl_o.op_b_sel     = OP_B_IMM;
      unique case (funct3[1:0])
        2'b00:   ctrl_o.data_type = DATA_BYTE;
        2'b01:   ctrl_o.data_type = DATA_HALF;
        default: ctrl_o.data_type = DATA_WORD; // 11 sorted out below
      endcase
      if (opcode == OPCODE_STORE) begin
        ctrl_o.data_we   = 1'b1;
        ctrl_o.imm_b_sel = IMMB_S;
        // no unsigned stores, no 64-bit size
        if (funct3[2] || (funct3[1:0] == 2'b11)) begin
          ctrl_o.data_req = 1'b0;
          ctrl_o.data_we  = 1'b0;
          ctrl_o.illegal  = 1'b1;
        end
      end else begin
        ctrl_o.regfile_we    = 1'b1;
        ctrl_o.imm_b_sel     = IMMB_I;
        ctrl_o.data_sign_ext = ~funct3[2]; // LBU/LHU zero-extend
        if (funct3 == 3'b011) begin
          ctrl_o.illegal = 1'b1; // LD, RV64 only
        end
      end
    end
  end

  // a write never goes out without its request
  assert final (!ctrl_o.data_we || ctrl_o.data_req)
    else $error("mem_access_decoder: data_we without data_req");

endmodule

/* hdl/alu_op_decoder.sv */
// ALU decoder for LUI, AUIPC, OP-IMM and OP
// RV32M multiply/divide decode enabled by parameter
module alu_op_decoder #(
  parameter bit RV32M = 1'b1
) (
  input  decoder_pkg::instr_req_t instr_i,
  output logic                    hit_o,
  output decoder_pkg::dec_ctrl_t  ctrl_o
);
  import decoder_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = opcode_e'(instr_i.instr[6:0]);
  assign funct3 = instr_i.instr[14:12];
  assign funct7 = instr_i.instr[31:25];
  assign hit_o  = (opcode == OPCODE_LUI) || (opcode == OPCODE_AUIPC) ||
                  (opcode == OPCODE_OPIMM) || (opcode == OPCODE_OP);

  always_comb begin
    ctrl_o = dec_ctrl_default;
    ctrl_o.regfile_we = hit_o; // every ALU group op writes rd
    unique case (opcode)
      OPCODE_LUI: begin
        ctrl_o.op_a_sel     = OP_A_IMM;  // 0 + u imm
        ctrl_o.op_b_sel     = OP_B_IMM;
        ctrl_o.imm_a_sel    = IMMA_ZERO;
        ctrl_o.imm_b_sel    = IMMB_U;
        ctrl_o.alu_operator = ALU_ADD;
      end
      OPCODE_AUIPC: begin
        ctrl_o.op_a_sel     = OP_A_CURRPC; // pc + u imm
        ctrl_o.op_b_sel     = OP_B_IMM;
        ctrl_o.imm_b_sel    = IMMB_U;
        ctrl_o.alu_operator = ALU_ADD;
      end
      OPCODE_OPIMM: begin
        ctrl_o.op_b_sel  = OP_B_IMM;
        ctrl_o.imm_b_sel = IMMB_I;
        unique case (funct3)
          3'b000: ctrl_o.alu_operator = ALU_ADD;
          3'b010: ctrl_o.alu_operator = ALU_SLTS;
          3'b011: ctrl_o.alu_operator = ALU_SLTU;
          3'b100: ctrl_o.alu_operator = ALU_XOR;
          3'b110: ctrl_o.alu_operator = ALU_OR;
          3'b111: ctrl_o.alu_operator = ALU_AND;
          3'b001: begin
            ctrl_o.alu_operator = ALU_SLL;
            ctrl_o.illegal      = (funct7 != 7'b000_0000);
          end
          default: begin // 101, shift right
            ctrl_o.alu_operator = (funct7 == 7'b010_0000) ? ALU_SRA : ALU_SRL;
            ctrl_o.illegal      = (funct7 != 7'b000_0000) && (funct7 != 7'b010_0000);
          end
        endcase
      end
      OPCODE_OP: begin
        if (funct7 == 7'b000_0001) begin
          // RV32M, funct3[2] splits mul from div/rem
          ctrl_o.alu_operator = ALU_ADD;
          ctrl_o.mult_en      = RV32M && !funct3[2];
          ctrl_o.div_en       = RV32M && funct3[2];
          ctrl_o.illegal      = !RV32M;
          unique case (funct3)
            3'b000: ctrl_o.md_operator = MD_OP_MULL;
            3'b001: begin
              ctrl_o.md_operator    = MD_OP_MULH;
              ctrl_o.md_signed_mode = 2'b11;
            end
            3'b010: begin
              ctrl_o.md_operator    = MD_OP_MULH; // mulhsu, rs1 signed only
              ctrl_o.md_signed_mode = 2'b01;
            end
            3'b011: ctrl_o.md_operator = MD_OP_MULH;
            3'b100: begin
              ctrl_o.md_operator    = MD_OP_DIV;
              ctrl_o.md_signed_mode = 2'b11;
            end
            3'b101: ctrl_o.md_operator = MD_OP_DIV;
            3'b110: begin
              ctrl_o.md_operator    = MD_OP_REM;
              ctrl_o.md_signed_mode = 2'b11;
            end
            default: ctrl_o.md_operator = MD_OP_REM; // remu
          endcase
        end else begin
          unique case ({funct7, funct3}) // bit 31 set lands in default
            {7'b000_0000, 3'b000}: ctrl_o.alu_operator = ALU_ADD;
            {7'b010_0000, 3'b000}: ctrl_o.alu_operator = ALU_SUB;
            {7'b000_0000, 3'b010}: ctrl_o.alu_operator = ALU_SLTS;
            {7'b000_0000, 3'b011}: ctrl_o.alu_operator = ALU_SLTU;
            {7'b000_0000, 3'b100}: ctrl_o.alu_operator = ALU_XOR;
            {7'b000_0000, 3'b110}: ctrl_o.alu_operator = ALU_OR;
            {7'b000_0000, 3'b111}: ctrl_o.alu_operator = ALU_AND;
            {7'b000_0000, 3'b001}: ctrl_o.alu_operator = ALU_SLL;
            {7'b000_0000, 3'b101}: ctrl_o.alu_operator = ALU_SRL;
            {7'b010_0000, 3'b101}: ctrl_o.alu_operator = ALU_SRA;
            default:               ctrl_o.illegal      = 1'b1;
          endcase
        end
      end
      default: ; // not an ALU group opcode
    endcase
  end

  // one multdiv unit, one enable at a time
  assert final (!(ctrl_o.mult_en && ctrl_o.div_en))
    else $error("alu_op_decoder: mult_en and div_en both set");

endmodule

/* hdl/system_decoder.sv */
// SYSTEM opcode decoder
// ecall, ebreak, mret, wfi and CSR read-modify-write
module system_decoder (
  input  decoder_pkg::instr_req_t instr_i,
  output logic                    hit_o,
  output decoder_pkg::dec_ctrl_t  ctrl_o
);
  import decoder_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [11:0] funct12; // csr address for csr ops
  logic       csr_illegal;

  assign opcode  = opcode_e'(instr_i.instr[6:0]);
  assign funct3  = instr_i.instr[14:12];
  assign funct12 = instr_i.instr[31:20];
  assign hit_o   = (opcode == OPCODE_SYSTEM);

  always_comb begin
    ctrl_o      = dec_ctrl_default;
    csr_illegal = 1'b0;
    if (hit_o && (funct3 == 3'b000)) begin
      unique case (funct12)
        12'h000: ctrl_o.ecall     = 1'b1;
        12'h001: ctrl_o.ebreak    = 1'b1;
        12'h302: ctrl_o.mret      = 1'b1;
        12'h105: ctrl_o.wfi_flush = 1'b1; // wfi flushes the pipe
        default: ctrl_o.illegal   = 1'b1;
      endcase
    end else if (hit_o) begin
      ctrl_o.csr_access = 1'b1;
      ctrl_o.regfile_we = 1'b1;      // old csr value to rd
      ctrl_o.op_b_sel   = OP_B_IMM;
      ctrl_o.imm_a_sel  = IMMA_Z;
      ctrl_o.imm_b_sel  = IMMB_I;    // address sits in the i imm
      ctrl_o.op_a_sel   = funct3[2] ? OP_A_IMM : OP_A_REGA; // csrr*i uses uimm
      unique case (funct3[1:0])
        2'b01:   ctrl_o.csr_op = CSR_OP_WRITE;
        2'b10:   ctrl_o.csr_op = CSR_OP_SET;
        2'b11:   ctrl_o.csr_op = CSR_OP_CLEAR;
        default: csr_illegal   = 1'b1;
      endcase
      ctrl_o.csr_status = !csr_illegal && (funct12 == 12'h300); // mstatus
      ctrl_o.illegal    = csr_illegal;
    end
  end

  // csr op only ever with the access flag
  assert final ((ctrl_o.csr_op == CSR_OP_NONE) || ctrl_o.csr_access)
    else $error("system_decoder: csr_op without csr_access");

endmodule

/* hdl/decode_output_stage.sv */
// decode output stage
// picks the claiming group, gates enables on stall, registers the result
module decode_output_stage (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   valid_i,
  input  logic                   stall_i,
  input  logic [3:0]             hit_i,
  input  decoder_pkg::dec_ctrl_t group_ctrl_i [4],
  output logic                   ctrl_valid_o,
  output decoder_pkg::dec_ctrl_t ctrl_o
);
  import decoder_pkg::*;

  dec_ctrl_t sel_ctrl;
  dec_ctrl_t gated_ctrl;

  //////////////////////////////
  // group select
  //////////////////////////////

  always_comb begin
    sel_ctrl         = dec_ctrl_default;
    sel_ctrl.illegal = 1'b1; // unknown opcode unless a group claims it
    for (int g = 0; g < 4; g++) begin
      if (hit_i[g]) begin
        sel_ctrl = group_ctrl_i[g];
      end
    end
  end

  // decode still happens when stalled but side effects do not
  always_comb begin
    gated_ctrl = sel_ctrl;
    if (stall_i) begin
      gated_ctrl.regfile_we = 1'b0;
      gated_ctrl.mult_en    = 1'b0;
      gated_ctrl.div_en     = 1'b0;
      gated_ctrl.data_req   = 1'b0;
      gated_ctrl.jump       = 1'b0;
      gated_ctrl.branch     = 1'b0;
      gated_ctrl.csr_op     = CSR_OP_NONE;
    end
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_valid_o <= 1'b0;
      ctrl_o       <= dec_ctrl_default;
    end else begin
      ctrl_valid_o <= valid_i;  // one-cycle pulse in cycle N+1
      if (valid_i) begin
        ctrl_o <= gated_ctrl;   // held between strobes
      end
    end
  end

  // opcode groups are disjoint across the four decoders
  assert property (@(posedge clk_i) disable iff (reset_i) valid_i |-> $onehot0(hit_i))
    else $error("decode_output_stage: more than one group claims the instruction");

endmodule

/* hdl/rv_decoder_top.sv */
// RV32 instruction decode stage
// four group decoders feeding one registered output stage
module rv_decoder_top #(
  parameter bit RV32M = 1'b1 // multiply/divide support
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    instr_valid_i, // one-cycle strobe
  input  decoder_pkg::instr_req_t instr_i,
  input  logic                    stall_i,       // clears side-effect enables
  output logic                    ctrl_valid_o,
  output decoder_pkg::dec_ctrl_t  ctrl_o
);
  import decoder_pkg::*;

  // group order 0 ctrl flow, 1 memory, 2 alu, 3 system
  logic [3:0] hit;
  dec_ctrl_t  group_ctrl [4];

  ctrl_flow_decoder u_ctrl_flow (
    .instr_i (instr_i),
    .hit_o   (hit[0]),
    .ctrl_o  (group_ctrl[0])
  );

  mem_access_decoder u_mem_access (
    .instr_i (instr_i),
    .hit_o   (hit[1]),
    .ctrl_o  (group_ctrl[1])
  );

  alu_op_decoder #(
    .RV32M (RV32M)
  ) u_alu_op (
    .instr_i (instr_i),
    .hit_o   (hit[2]),
    .ctrl_o  (group_ctrl[2])
  );

  system_decoder u_system (
    .instr_i (instr_i),
    .hit_o   (hit[3]),
    .ctrl_o  (group_ctrl[3])
  );

  decode_output_stage u_output_stage (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .valid_i      (instr_valid_i),
    .stall_i      (stall_i),
    .hit_i        (hit),
    .group_ctrl_i (group_ctrl),
    .ctrl_valid_o (ctrl_valid_o),
    .ctrl_o       (ctrl_o)
  );

endmodule

/* test/decode_checker.sv */
// result checker for the decode stage
// samples on the falling edge, compares each result with its table row
module decode_checker (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   instr_valid_i,
  input  logic [7:0]             test_num_i,
  input  decoder_pkg::dec_ctrl_t expect_i,
  input  logic                   ctrl_valid_i,
  input  decoder_pkg::dec_ctrl_t ctrl_i,
  output int                     checked_o,
  output int                     pass_count_o,
  output int                     fail_count_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import decoder_pkg::*;

  // SLTU, imm a zero, every enable and flag low
  localparam logic [39:0] reset_ctrl = 40'h0C08_000000;

  logic       pending    = 1'b0; // strobe seen, result due next cycle
  logic       reset_seen = 1'b0;
  logic [7:0] pend_num   = '0;
  dec_ctrl_t  pend_exp   = '0;
  int         checked    = 0;
  int         passed     = 0;
  int         failed     = 0;

  assign checked_o    = checked;
  assign pass_count_o = passed;
  assign fail_count_o = failed;

  task automatic check_reset_state();
    reset_seen = 1'b1;
    checked++;
    if (ctrl_valid_i !== 1'b0) begin
      $display("ERROR reset: ctrl_valid_o is high right after reset");
      failed++;
    end else if (ctrl_i !== reset_ctrl) begin
      $display("FAIL reset: expected %h, actual %h", reset_ctrl, ctrl_i);
      failed++;
    end else begin
      $display("PASS reset");
      passed++;
    end
  endtask

  task automatic check_result();
    checked++;
    if (ctrl_valid_i !== 1'b1) begin
      $display("ERROR test %0d: ctrl_valid_o did not rise one cycle after the strobe",
               pend_num);
      failed++;
    end else if (ctrl_i !== pend_exp) begin
      $display("FAIL test %0d: expected %h, actual %h", pend_num, pend_exp, ctrl_i);
      failed++;
    end else begin
      $display("PASS test %0d", pend_num);
      passed++;
    end
  endtask

  //////////////////////////////
  // falling-edge monitor
  //////////////////////////////

  always @(negedge clk_i) begin
    if (reset_i) begin
      pending = 1'b0;
    end else begin
      if (!reset_seen) begin
        check_reset_state();
      end
      if (pending) begin
        check_result();
      end else if (ctrl_valid_i) begin
        $display("ERROR: ctrl_valid_o went high with no strobe in the cycle before");
        failed++;
      end
      pending  = instr_valid_i; // next strobe, possibly back-to-back
      pend_num = test_num_i;
      pend_exp = expect_i;
    end
  end

endmodule

/* test/tb_rv_decoder.sv */
// testbench top for the RV32 decode stage
// clock, reset, table-driven strobes, watchdog and the final verdict
module tb_rv_decoder;
  timeunit 1ns;
  timeprecision 1ps;
  import decoder_pkg::*;

  localparam int clk_period   = 40;
  localparam int reset_cycles = 16;
  localparam int drive_delay  = 2;   // after the rising edge
  localparam int row_words    = 6;   // test, instr, phase, stall, burst, expected
  localparam int max_rows     = 64;

  logic       clk_i;
  logic       reset_i;
  logic       instr_valid_i;
  logic       stall_i;
  instr_req_t instr_i;
  logic       ctrl_valid_o;
  dec_ctrl_t  ctrl_o;

  logic [39:0] table_mem [row_words * max_rows];
  dec_ctrl_t   expect_ctrl;          // expected result of the row on the bus
  logic [7:0]  test_num;
  logic        table_loaded;
  int          n_rows;
  int          checked;
  int          pass_count;
  int          fail_count;

  rv_decoder_top #(
    .RV32M (1'b1)
  ) rv_decoder_top_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .stall_i       (stall_i),
    .ctrl_valid_o  (ctrl_valid_o),
    .ctrl_o        (ctrl_o)
  );

  decode_checker u_checker (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .test_num_i    (test_num),
    .expect_i      (expect_ctrl),
    .ctrl_valid_i  (ctrl_valid_o),
    .ctrl_i        (ctrl_o),
    .checked_o     (checked),
    .pass_count_o  (pass_count),
    .fail_count_o  (fail_count)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  // one strobe per row, idle cycle after it unless burst is set
  task automatic drive_row(input int r);
    int base;
    base = r * row_words;
    @(posedge clk_i);
    #drive_delay;
    test_num             = table_mem[base][7:0];
    instr_i.instr        = table_mem[base + 1][31:0];
    instr_i.target_phase = table_mem[base + 2][0];
    stall_i              = table_mem[base + 3][0];
    expect_ctrl          = table_mem[base + 5];
    instr_valid_i        = 1'b1;
    if (table_mem[base + 4][0] == 1'b0) begin
      @(posedge clk_i);
      #drive_delay;
      instr_valid_i = 1'b0;
      stall_i       = 1'b0;
    end
  endtask

  initial begin
    reset_i       = 1'b1;
    instr_valid_i = 1'b0;
    stall_i       = 1'b0;
    instr_i       = '0;
    expect_ctrl   = '0;
    test_num      = '0;
    table_loaded  = 1'b0;
    n_rows        = 0;
    $readmemh("test/decode_input.txt", table_mem);
    // table ends at the first empty test number
    while ((n_rows < max_rows) && (table_mem[n_rows * row_words] !== '0) &&
           !$isunknown(table_mem[n_rows * row_words])) begin
      n_rows++;
    end
    if (n_rows == 0) begin
      $display("no test rows could be read from test/decode_input.txt");
      $display("TESTS FAILED");
      $finish;
    end else begin
      table_loaded = 1'b1;
      repeat (reset_cycles) @(posedge clk_i);
      #drive_delay;
      reset_i = 1'b0;
      repeat (2) @(posedge clk_i);  // leave room for the reset-state check
      for (int r = 0; r < n_rows; r++) begin
        drive_row(r);
      end
      @(posedge clk_i);
      #drive_delay;
      instr_valid_i = 1'b0;
      stall_i       = 1'b0;
      wait (checked == n_rows + 1);  // every row plus the reset state
      $display("%0d checks, %0d passed, %0d failed", checked, pass_count, fail_count);
      if ((fail_count == 0) && (pass_count == n_rows + 1)) begin
        $display("TESTS PASSED");
      end else begin
        $display("TESTS FAILED");
      end
      $finish;
    end
  end

  // two periods per row plus reset and slack
  initial begin
    wait (table_loaded);
    #((n_rows * 2 + 40) * clk_period);
    $display("watchdog expired after %0d clock periods with %0d of %0d checks done",
             n_rows * 2 + 40, checked, n_rows + 1);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* test/decode_input.txt */
// columns: test  instr  target_phase  stall  burst  expected dec_ctrl_t (40 bits, hex)
// burst 1 drives the next row in the very next cycle
01 123450B7 0 0 0 6129010000 // lui
02 00001117 0 0 0 60A9010000 // auipc
03 00508193 0 0 0 6028010000 // addi
04 4030D213 0 0 0 9028010000 // srai
05 402082B3 0 0 0 6408010000 // sub
06 0020B333 0 0 0 0C08010000 // sltu
07 022083B3 0 0 0 6008410000 // mul
08 0220A433 0 0 0 60084B0000 // mulhsu
09 0220D4B3 0 0 0 6008310000 // divu
0A 0220E533 0 0 0 60083F0000 // rem
0B 008000EF 1 0 0 60AE000040 // jal, target phase
0C 008000EF 0 0 0 60A9810040 // jal, link phase
0D 000100E7 1 0 0 6028000040 // jalr, target phase
0E 000100E7 0 0 0 60A9810040 // jalr, link phase
0F 000110E7 1 0 0 6028000010 // jalr funct3 001
10 00208863 1 0 0 3008000020 // beq, compare phase
11 00208863 0 0 0 60AE800020 // beq, target add phase
12 0020F863 1 0 0 2C08000020 // bgeu
13 0020A863 1 0 0 0C08000030 // branch funct3 010
14 00408183 0 0 0 6028010A80 // lb
15 0040D183 0 0 0 6028010900 // lhu
16 0040A183 0 0 0 6028010880 // lw
17 00209423 0 0 0 6028800D00 // sh
18 0020A423 0 0 0 6028800C00 // sw
19 0020B423 0 0 0 6028800010 // store size 11
1A 0040B183 0 0 0 6028010890 // load funct3 011
1B 00000073 0 0 1 0C08000008 // ecall, burst
1C 00100073 0 0 1 0C08000004 // ebreak, burst
1D 30200073 0 0 1 0C08000002 // mret, burst
1E 10500073 0 0 0 0C08000001 // wfi
1F 300110F3 0 0 0 0C2001B000 // csrrw mstatus
20 3412F0F3 0 0 0 0D2001E000 // csrrci mepc
21 300140F3 0 0 0 0D20018010 // csr funct3 100
22 0000007F 0 0 0 0C08000010 // unknown opcode
23 00508193 0 1 0 6028000000 // addi, stalled
24 300110F3 0 1 0 0C20009000 // csrrw, stalled
25 0020A423 0 1 1 6028800400 // sw, stalled, burst
26 008000EF 0 1 1 60A9800000 // jal link, stalled, burst
27 022083B3 0 0 0 6008410000 // mul right after stalled rows

/* rv_decoder_top.f */
hdl/decoder_pkg.sv
hdl/ctrl_flow_decoder.sv
hdl/mem_access_decoder.sv
hdl/alu_op_decoder.sv
hdl/system_decoder.sv
hdl/decode_output_stage.sv
hdl/rv_decoder_top.sv
test/decode_checker.sv
test/tb_rv_decoder.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_rv_decoder \
  -f rv_decoder_top.f -o tb_rv_decoder &&
  ./obj_dir/tb_rv_decoder | tee sim.log &&
  grep -qx "TESTS PASSED" sim.log || { echo "simulation did not pass, see sim.log"; exit 1; }
